/* adc_rx_macros.svh */
`ifndef ADC_RX_MACROS_SVH
`define ADC_RX_MACROS_SVH

//////////////////////////////////////////////////
// Phase alignment

// Cycles per phase-error window
`define ADC_PHASE_WINDOW 256

// Frame clock high for bits 0-3, low for bits 4-7
`define ADC_FRAME_NOMINAL 8'h0f

// Length of the SERDES reset pulse after init
`define ADC_SERDES_RST_CYCLES 3

//////////////////////////////////////////////////
// Register map, word addresses

`define ADC_REG_CTRL 3'd0
`define ADC_REG_THRESH 3'd1
`define ADC_REG_STATUS 3'd2
`define ADC_REG_ERRS 3'd3
`define ADC_REG_SNAP_LO 3'd4
`define ADC_REG_SNAP_HI 3'd5

// CTRL reset: all lanes inverted (bits 7..0), frame inverted (bit 8)
`define ADC_CTRL_RESET 9'h1ff

// Errors tolerated per window before a bitslip
`define ADC_THRESH_RESET 8'd16

`endif

/* adc_rx_pkg.sv */
`default_nettype none

// Shared types for the slow_clk ADC receive path
package adc_rx_pkg;

	// One ADC sample as it leaves the 8:1 deserializer
	typedef logic [7:0] sample_t;

	// Eight frame-clock bits captured in one slow_clk cycle
	typedef logic [7:0] frame_word_t;

	//////////////////////////////////////////////////
	// Sample block

	// One slow_clk cycle of the eight data lanes
	// samples view: index 0 newest, index 7 oldest
	// words view: two bus words, index 0 is the low half
	typedef union packed {
		sample_t [7:0]     samples;
		logic [1:0][31:0]  words;
	} sample_block_u;

endpackage

`default_nettype wire

/* lane_polarity.sv */
`timescale 1ns/1ns
`default_nettype none

// Stage 1 of the receive path
// Undoes P/N pin swaps on each data lane and on the frame lane
module lane_polarity (
	input wire                          slow_clk,
	input wire                          rst_done_sync,
	input wire adc_rx_pkg::sample_block_u lane_data,
	input wire adc_rx_pkg::frame_word_t   frame_data,
	input wire [7:0]                    lane_invert,
	input wire                          frame_invert,
	output adc_rx_pkg::sample_block_u   pol_block,
	output adc_rx_pkg::frame_word_t     pol_frame
);

	import adc_rx_pkg::*;

	// Corrected values ahead of the stage register
	sample_block_u corr_block;
	frame_word_t   corr_frame;

	//////////////////////////////////////////////////
	// Polarity correction

	always_comb begin
		// Lane i is one sample slot of the block
		for (int i = 0; i < 8; i++) begin
			corr_block.samples[i] = lane_data.samples[i] ^ {8{lane_invert[i]}};
		end
		// Frame lane has its own invert bit
		corr_frame = frame_data ^ {8{frame_invert}};
	end

	//////////////////////////////////////////////////
	// Stage register

	// One cycle of latency, new block every cycle
	always_ff @(posedge slow_clk) begin
		if (rst_done_sync) begin
			pol_block <= '0;
			pol_frame <= '0;
		end else begin
			pol_block <= corr_block;
			pol_frame <= corr_frame;
		end
	end

endmodule

`default_nettype wire

/* frame_align.sv */
`timescale 1ns/1ns
`default_nettype none

`include "adc_rx_macros.svh"

// Stage 2 of the receive path
// Resets the SERDES, then checks the frame word once per cycle
// Too many misaligned frames in a window requests a bitslip
module frame_align (
	input wire                          slow_clk,
	input wire                          rst_done_sync,
	input wire adc_rx_pkg::sample_block_u pol_block,
	input wire adc_rx_pkg::frame_word_t   pol_frame,
	input wire [7:0]                    err_threshold,
	output logic                        serdes_reset,
	output logic                        bitslip,
	output logic                        locked,
	output logic [8:0]                  window_errs,
	output adc_rx_pkg::sample_block_u   sample_out,
	output logic                        sample_valid
);

	import adc_rx_pkg::*;

	localparam frame_word_t FRAME_NOMINAL = `ADC_FRAME_NOMINAL;

	// SERDES reset sequencer
	logic [1:0] rst_cnt;

	// Window position and errors seen so far in it
	logic [7:0] win_cnt;
	logic [7:0] err_cnt;

	logic       frame_err;
	logic [8:0] err_total;
	logic       win_last;

	//////////////////////////////////////////////////
	// Window bookkeeping

	assign frame_err = (pol_frame != FRAME_NOMINAL);

	// Count including the current cycle, 0 to 256
	assign err_total = {1'b0, err_cnt} + {8'd0, frame_err};

	assign win_last = (win_cnt == 8'(`ADC_PHASE_WINDOW - 1));

	//////////////////////////////////////////////////
	// SERDES reset and phase alignment

	always_ff @(posedge slow_clk) begin
		if (rst_done_sync) begin
			// SERDES stays in reset while init is incomplete
			serdes_reset <= 1'b1;
			rst_cnt      <= '0;
			win_cnt      <= '0;
			err_cnt      <= '0;
			bitslip      <= 1'b0;
			locked       <= 1'b0;
			window_errs  <= '0;
		end else begin
			// Bitslip is a single-cycle request
			bitslip <= 1'b0;

			if (serdes_reset) begin
				rst_cnt <= rst_cnt + 2'd1;
				if (rst_cnt == 2'(`ADC_SERDES_RST_CYCLES - 1)) begin
					serdes_reset <= 1'b0;
				end
			end else begin
				// Window runs from the first cycle out of reset
				win_cnt <= win_cnt + 8'd1;

				if (win_last) begin
					err_cnt     <= '0;
					window_errs <= err_total;
					// Lock follows each window result
					locked      <= (err_total <= {1'b0, err_threshold});
					// Slip one bit and try the next phase
					bitslip     <= (err_total > {1'b0, err_threshold});
				end else begin
					err_cnt <= err_total[7:0];
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Sample output

	// Data path register, one cycle behind pol_block
	always_ff @(posedge slow_clk) begin
		sample_out <= pol_block;
	end

	// Samples only count when the lanes are aligned
	assign sample_valid = locked && !serdes_reset;

endmodule

`default_nettype wire

/* adc_rx_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "adc_rx_macros.svh"

// Wishbone classic slave for the receive path
// Control and threshold out, status, errors and sample snapshot in
module adc_rx_regs (
	input wire                          slow_clk,
	input wire                          rst_done_sync,

	// Wishbone classic, word addressed
	input wire                          wb_cyc,
	input wire                          wb_stb,
	input wire                          wb_we,
	input wire [2:0]                    wb_adr,
	input wire [31:0]                   wb_dat_w,
	output logic [31:0]                 wb_dat_r,
	output logic                        wb_ack,

	// From frame_align
	input wire                          bitslip,
	input wire                          locked,
	input wire [8:0]                    window_errs,
	input wire adc_rx_pkg::sample_block_u sample_out,
	input wire                          sample_valid,

	// To the pipeline stages
	output logic [7:0]                  lane_invert,
	output logic                        frame_invert,
	output logic [7:0]                  err_threshold
);

	import adc_rx_pkg::*;

	// CTRL bits 7..0 lane mask, bit 8 frame invert
	logic [8:0]    ctrl_q;
	logic [7:0]    thresh_q;

	// Wrapping count of bitslip pulses
	logic [7:0]    slip_cnt;

	// Last block seen with sample_valid
	sample_block_u snap;

	logic          wb_req;
	logic [31:0]   rd_data;

	// New cycle, not yet acknowledged
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	assign lane_invert   = ctrl_q[7:0];
	assign frame_invert  = ctrl_q[8];
	assign err_threshold = thresh_q;

	//////////////////////////////////////////////////
	// Read mux

	always_comb begin
		case (wb_adr)
			`ADC_REG_CTRL:    rd_data = {23'd0, ctrl_q};
			`ADC_REG_THRESH:  rd_data = {24'd0, thresh_q};
			`ADC_REG_STATUS:  rd_data = {16'd0, slip_cnt, 7'd0, locked};
			`ADC_REG_ERRS:    rd_data = {23'd0, window_errs};
			`ADC_REG_SNAP_LO: rd_data = snap.words[0];
			`ADC_REG_SNAP_HI: rd_data = snap.words[1];
			// Unmapped addresses
			default:          rd_data = 32'd0;
		endcase
	end

	//////////////////////////////////////////////////
	// Handshake, control registers, slip counter

	always_ff @(posedge slow_clk) begin
		if (rst_done_sync) begin
			wb_ack   <= 1'b0;
			ctrl_q   <= `ADC_CTRL_RESET;
			thresh_q <= `ADC_THRESH_RESET;
			slip_cnt <= '0;
		end else begin
			// Ack exactly one cycle after the request
			wb_ack <= wb_req;

			if (bitslip) begin
				slip_cnt <= slip_cnt + 8'd1;
			end

			// Write lands on the same edge that raises ack
			if (wb_req && wb_we) begin
				case (wb_adr)
					`ADC_REG_CTRL:   ctrl_q   <= wb_dat_w[8:0];
					`ADC_REG_THRESH: thresh_q <= wb_dat_w[7:0];
					// Read-only and unmapped, ignored
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Read data and snapshot

	always_ff @(posedge slow_clk) begin
		// Valid while wb_ack is high
		if (wb_req) begin
			wb_dat_r <= rd_data;
		end
		if (sample_valid) begin
			snap <= sample_out;
		end
	end

endmodule

`default_nettype wire

/* adc_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

// Receive path top: polarity stage, alignment stage, register block
// Input block reaches sample_out two cycles later
module adc_rx_top (
	input wire                          slow_clk,
	input wire                          rst_done_sync,

	// Deserialized lanes, one block per cycle
	input wire adc_rx_pkg::sample_block_u lane_data,
	input wire adc_rx_pkg::frame_word_t   frame_data,

	// Wishbone classic
	input wire                          wb_cyc,
	input wire                          wb_stb,
	input wire                          wb_we,
	input wire [2:0]                    wb_adr,
	input wire [31:0]                   wb_dat_w,
	output logic [31:0]                 wb_dat_r,
	output logic                        wb_ack,

	// Back to the SERDES primitives
	output logic                        serdes_reset,
	output logic                        bitslip,

	// Qualified samples
	output adc_rx_pkg::sample_block_u   sample_out,
	output logic                        sample_valid
);

	import adc_rx_pkg::*;

	// Stage 1 to stage 2
	sample_block_u pol_block;
	frame_word_t   pol_frame;

	// Register block to the stages
	logic [7:0]    lane_invert;
	logic          frame_invert;
	logic [7:0]    err_threshold;

	// Alignment status to the register block
	logic          locked;
	logic [8:0]    window_errs;

	//////////////////////////////////////////////////
	// Pipeline

	lane_polarity u_pol (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.lane_data     (lane_data),
		.frame_data    (frame_data),
		.lane_invert   (lane_invert),
		.frame_invert  (frame_invert),
		.pol_block     (pol_block),
		.pol_frame     (pol_frame)
	);

	frame_align u_align (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.pol_block     (pol_block),
		.pol_frame     (pol_frame),
		.err_threshold (err_threshold),
		.serdes_reset  (serdes_reset),
		.bitslip       (bitslip),
		.locked        (locked),
		.window_errs   (window_errs),
		.sample_out    (sample_out),
		.sample_valid  (sample_valid)
	);

	//////////////////////////////////////////////////
	// Software access

	adc_rx_regs u_regs (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.bitslip       (bitslip),
		.locked        (locked),
		.window_errs   (window_errs),
		.sample_out    (sample_out),
		.sample_valid  (sample_valid),
		.lane_invert   (lane_invert),
		.frame_invert  (frame_invert),
		.err_threshold (err_threshold)
	);

endmodule

`default_nettype wire

/* adc_rx_properties.sv */
`timescale 1ns/1ns
`default_nettype none

// Handshake and pipeline rules for the receive path
module adc_rx_properties (
	input wire slow_clk,
	input wire rst_done_sync,
	input wire wb_stb,
	input wire wb_ack,
	input wire bitslip,
	input wire locked,
	input wire serdes_reset,
	input wire sample_valid
);

	//////////////////////////////////////////////////
	// Wishbone

	// Single-cycle ack after which the master releases the strobe
	ack_single: assert property (@(posedge slow_clk) disable iff (rst_done_sync)
		wb_ack |=> (!wb_ack && !wb_stb))
		else $error("wb_ack longer than one cycle or wb_stb held after ack");

	//////////////////////////////////////////////////
	// Alignment stage

	// Lock is only lost at a window end that also requests a bitslip
	// SERDES never goes back into reset once samples are qualified
	valid_until_slip: assert property (@(posedge slow_clk) disable iff (rst_done_sync)
		sample_valid |=> ((locked || bitslip) && !serdes_reset))
		else $error("lock lost without bitslip or SERDES reset after valid samples");

	// Bitslip request lasts one cycle
	slip_pulse: assert property (@(posedge slow_clk) disable iff (rst_done_sync)
		bitslip |=> !bitslip)
		else $error("bitslip longer than one cycle");

endmodule

bind adc_rx_top adc_rx_properties u_props (
	.slow_clk      (slow_clk),
	.rst_done_sync (rst_done_sync),
	.wb_stb        (wb_stb),
	.wb_ack        (wb_ack),
	.bitslip       (bitslip),
	.locked        (locked),
	.serdes_reset  (serdes_reset),
	.sample_valid  (sample_valid)
);

`default_nettype wire

/* tb_adc_rx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "adc_rx_macros.svh"

// Directed testbench for the ADC receive path
// The ADC model drives P/N-swapped lanes and a frame lane a few bits off phase
module tb_adc_rx;

	import adc_rx_pkg::*;

	// DUT inputs
	logic          slow_clk = 1'b0;
	logic          rst_done_sync = 1'b1;
	sample_block_u lane_data = '0;
	frame_word_t   frame_data = '0;
	logic          wb_cyc = 1'b0;
	logic          wb_stb = 1'b0;
	logic          wb_we = 1'b0;
	logic [2:0]    wb_adr = '0;
	logic [31:0]   wb_dat_w = '0;

	// DUT outputs
	logic [31:0]   wb_dat_r;
	logic          wb_ack;
	logic          serdes_reset;
	logic          bitslip;
	sample_block_u sample_out;
	logic          sample_valid;

	// ADC model frame phase starts three bits off
	integer        seed = 32'h59c6;
	logic [2:0]    slip_offset = 3'd3;
	// Lane mask as software last wrote it
	logic [7:0]    tb_mask = 8'hff;
	// Expected block after stage 1 and at sample_out
	sample_block_u exp_pol = '0;
	sample_block_u exp_out = '0;

	// Monitor state
	logic          slip_now = 1'b0;
	int            slip_seen = 0;
	sample_block_u snap_exp = '0;

	int            mismatch_count = 0;
	int            timeout_count = 0;

	adc_rx_top uut (
		.slow_clk      (slow_clk),
		.rst_done_sync (rst_done_sync),
		.lane_data     (lane_data),
		.frame_data    (frame_data),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.serdes_reset  (serdes_reset),
		.bitslip       (bitslip),
		.sample_out    (sample_out),
		.sample_valid  (sample_valid)
	);

	initial begin
		forever #5 slow_clk = ~slow_clk;
	end

	//////////////////////////////////////////////////
	// ADC model and monitor

	// Frame word seen n bit times late is rotated left
	function automatic frame_word_t rotate_frame(frame_word_t w, logic [2:0] n);
		logic [15:0] both;
		both = {w, w} << n;
		return both[15:8];
	endfunction

	// Lane i inverted where mask bit i is set
	function automatic sample_block_u apply_mask(sample_block_u blk, logic [7:0] mask);
		return blk ^ {{8{mask[7]}}, {8{mask[6]}}, {8{mask[5]}}, {8{mask[4]}},
			{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
	endfunction

	always @(posedge slow_clk) begin : adc_model
		sample_block_u raw;
		logic [2:0]    next_offset;
		raw.words[0] = $random(seed);
		raw.words[1] = $random(seed);
		// Each bitslip moves the frame one bit toward the nominal phase
		next_offset = slip_now ? slip_offset - 3'd1 : slip_offset;
		slip_offset <= next_offset;
		// Lanes and frame arrive with swapped pins
		lane_data  <= ~raw;
		frame_data <= ~rotate_frame(`ADC_FRAME_NOMINAL, next_offset);
		// Expected pipeline uses the mask in effect at this edge
		exp_pol <= apply_mask(lane_data, tb_mask);
		exp_out <= exp_pol;
	end

	// Mid-cycle sampling of pulses and of the block that the snapshot takes
	always @(negedge slow_clk) begin
		slip_now = (bitslip === 1'b1);
		if (bitslip === 1'b1) begin
			slip_seen++;
		end
		if (sample_valid === 1'b1) begin
			snap_exp = exp_out;
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks

	task automatic check_block(input string what, input sample_block_u got,
		input sample_block_u exp);
		for (int i = 0; i < 8; i++) begin
			if (got.samples[i[2:0]] !== exp.samples[i[2:0]]) begin
				$display("Mismatch at %0t: %s sample %0d is %h, expected %h", $time, what, i,
					got.samples[i[2:0]], exp.samples[i[2:0]]);
				mismatch_count++;
			end
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	//////////////////////////////////////////////////
	// Wishbone master

	task automatic wb_access(input logic we, input logic [2:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		rdata = '0;
		@(posedge slow_clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		@(negedge slow_clk);
		while (wb_ack !== 1'b1 && waited < 16) begin
			@(negedge slow_clk);
			waited++;
		end
		if (wb_ack === 1'b1) begin
			rdata = wb_dat_r;
			// Lane mask takes effect on the edge after this ack
			if (we && adr == `ADC_REG_CTRL) begin
				tb_mask = wdata[7:0];
			end
		end else begin
			$display("Timeout: no wb_ack for address %0d", adr);
			timeout_count++;
		end
		@(posedge slow_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
		logic [31:0] ignored;
		wb_access(1'b1, adr, data, ignored);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
		wb_access(1'b0, adr, 32'd0, data);
	endtask

	task automatic compare_stream(input int cycles, input string what);
		repeat (cycles) begin
			@(negedge slow_clk);
			check_bit("sample_valid", sample_valid, 1'b1);
			check_block(what, sample_out, exp_out);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic serdes_reset_pulse();
		int high_cycles;
		int waited;
		high_cycles = 0;
		waited = 0;
		@(negedge slow_clk);
		// Flags idle straight out of reset
		check_bit("bitslip after reset", bitslip, 1'b0);
		check_bit("sample_valid after reset", sample_valid, 1'b0);
		check_bit("wb_ack after reset", wb_ack, 1'b0);
		while (serdes_reset === 1'b1 && waited < 16) begin
			high_cycles++;
			@(negedge slow_clk);
			waited++;
		end
		if (serdes_reset !== 1'b0) begin
			$display("Timeout: serdes_reset still high after %0d cycles", waited);
			timeout_count++;
		end
		check_word("serdes_reset cycles", 32'(high_cycles), 32'(`ADC_SERDES_RST_CYCLES));
	endtask

	task automatic register_defaults_rw();
		logic [31:0] rd;
		wb_read(`ADC_REG_CTRL, rd);
		check_word("CTRL after reset", rd, 32'h1ff);
		wb_read(`ADC_REG_THRESH, rd);
		check_word("THRESH after reset", rd, 32'd16);
		wb_read(`ADC_REG_STATUS, rd);
		check_word("STATUS after reset", rd, 32'd0);
		// Frame invert stays set so the lock search runs as usual
		wb_write(`ADC_REG_CTRL, 32'h1a5);
		wb_read(`ADC_REG_CTRL, rd);
		check_word("CTRL readback", rd, 32'h1a5);
		wb_write(`ADC_REG_THRESH, 32'h25);
		wb_read(`ADC_REG_THRESH, rd);
		check_word("THRESH readback", rd, 32'h25);
		wb_write(`ADC_REG_STATUS, 32'hffff_ffff);
		wb_read(`ADC_REG_STATUS, rd);
		check_word("STATUS after write", rd, 32'd0);
		wb_write(`ADC_REG_CTRL, 32'h1ff);
		wb_write(`ADC_REG_THRESH, 32'd16);
	endtask

	task automatic acquire_lock();
		logic [31:0] rd;
		int          waited;
		waited = 0;
		// One full window per slip from offset 3 down to 0
		while (sample_valid !== 1'b1 && waited < 5 * `ADC_PHASE_WINDOW) begin
			@(negedge slow_clk);
			waited++;
		end
		if (sample_valid !== 1'b1) begin
			$display("Timeout: no lock after %0d cycles", waited);
			timeout_count++;
		end
		wb_read(`ADC_REG_STATUS, rd);
		check_word("STATUS when locked", rd, {16'd0, 8'(slip_seen), 7'd0, 1'b1});
		check_word("bitslip pulses to lock", 32'(slip_seen), 32'd3);
		wb_read(`ADC_REG_ERRS, rd);
		check_bit("ERRS within threshold", rd <= 32'd16, 1'b1);
	endtask

	task automatic remask_lanes();
		wb_write(`ADC_REG_CTRL, 32'h13c);
		// Mask change reaches sample_out after the two pipeline stages
		repeat (4) @(posedge slow_clk);
		compare_stream(32, "remasked block");
	endtask

	task automatic lose_frame_lock();
		logic [31:0] rd;
		int          start;
		int          waited;
		waited = 0;
		start = slip_seen;
		wb_write(`ADC_REG_CTRL, {23'd0, 1'b0, tb_mask});
		// The second pulse ends a window run wholly with the wrong polarity
		while (slip_seen < start + 2 && waited < 3 * `ADC_PHASE_WINDOW + 16) begin
			@(posedge slow_clk);
			waited++;
		end
		if (slip_seen < start + 2) begin
			$display("Timeout: frame errors gave no bitslip within %0d cycles", waited);
			timeout_count++;
		end
		@(negedge slow_clk);
		check_bit("sample_valid with frame errors", sample_valid, 1'b0);
		wb_read(`ADC_REG_ERRS, rd);
		check_word("ERRS with frame errors", rd, 32'(`ADC_PHASE_WINDOW));
		wb_read(`ADC_REG_STATUS, rd);
		check_bit("locked with frame errors", rd[0], 1'b0);
		// Register block counts the same pulses as the monitor
		check_word("STATUS bitslip count", {24'd0, rd[15:8]}, {24'd0, 8'(slip_seen)});
	endtask

	task automatic snapshot_readback();
		logic [31:0] rd;
		wb_read(`ADC_REG_SNAP_LO, rd);
		check_word("SNAP_LO", rd, snap_exp.words[0]);
		wb_read(`ADC_REG_SNAP_HI, rd);
		check_word("SNAP_HI", rd, snap_exp.words[1]);
	endtask

	initial begin
		repeat (2) @(posedge slow_clk);
		rst_done_sync <= 1'b0;
		serdes_reset_pulse();
		register_defaults_rw();
		acquire_lock();
		compare_stream(32, "locked block");
		remask_lanes();
		lose_frame_lock();
		snapshot_readback();
		$display("Error count: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
adc_rx_pkg.sv
lane_polarity.sv
frame_align.sv
adc_rx_regs.sv
adc_rx_top.sv
adc_rx_properties.sv
tb_adc_rx.sv

/* Makefile */
# Verilator flow for the ADC receive path

TOP = tb_adc_rx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

# Build, run, and pass only if the testbench printed its pass line
sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir
